// File: dv/leaf_i4o2_assert.sv
module leaf_i4o2_assert (
    input logic              clk_400,
    input logic              arst_n,
    input logic              resend,
    input leaf_pkg::packet_t dout
);
    timeunit 1ns;
    timeprecision 100ps;

    // line is quiet in the cycle after resend
    a_resend_quiet : assert property (
        @(posedge clk_400) disable iff (!arst_n)
        resend |=> !dout.hdr.valid
    ) else $error("dout valid in the cycle after resend");

    // port 0 is configuration and never leaves the leaf
    a_no_port_0 : assert property (
        @(posedge clk_400) disable iff (!arst_n)
        dout.hdr.valid |-> (dout.hdr.port != '0)
    ) else $error("packet sent with port 0");

    a_reset_quiet : assert property (
        @(posedge clk_400)
        !arst_n |-> !dout.hdr.valid
    ) else $error("dout valid during reset");

endmodule

bind leaf_i4o2 leaf_i4o2_assert i_assert (
    .clk_400 (clk_400),
    .arst_n  (arst_n),
    .resend  (resend),
    .dout    (dout)
);

// File: include/leaf_tb_settings.svh
`ifndef LEAF_TB_SETTINGS_SVH
`define LEAF_TB_SETTINGS_SVH

// **************************************************
// testbench destinations
// **************************************************
`define TB_OUT1_LEAF 5'd9
`define TB_OUT1_PORT 4'd2
`define TB_OUT2_LEAF 5'd12
`define TB_OUT2_PORT 4'd5

`endif

// File: dv/leaf_i4o2_tb.sv
`include "leaf_settings.svh"
`include "leaf_tb_settings.svh"

module leaf_i4o2_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import leaf_pkg::*;

    typedef struct {
        packet_t pkt;
        logic    resend;
        int      idle;
        logic    mark;
    } stim_t;

    logic    clk_400;
    logic    arst_n;
    logic    resend;
    packet_t din;
    packet_t dout;

    stim_t   table_q[$];
    word_t   mq[4][$];
    packet_t exp_1[$];
    packet_t exp_2[$];
    route_t  model_route_1;
    route_t  model_route_2;
    int      err_count;
    int      out1_seen;
    int      mark_count;
    int      cycle;
    int      limit;

    leaf_i4o2 i_dut (
        .clk_400 (clk_400),
        .arst_n  (arst_n),
        .din     (din),
        .dout    (dout),
        .resend  (resend)
    );

    initial begin
        clk_400 = 1'b0;
        forever #2 clk_400 = ~clk_400;
    end

    // **************************************************
    // compare tasks
    // **************************************************
    task automatic check_packet(input string name, input packet_t got, input packet_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    // **************************************************
    // table building
    // **************************************************
    task automatic store_entry(input packet_t p, input logic rs, input int idle,
                               input logic mark);
        stim_t e;
        e.pkt = p;
        e.resend = rs;
        e.idle = idle;
        e.mark = mark;
        table_q.push_back(e);
    endtask

    task automatic data_entry(input logic [3:0] port, input word_t w, input logic rs);
        packet_t p;
        p = '0;
        p.hdr.valid = 1'b1;
        p.hdr.leaf = `LEAF_OWN_ID;
        p.hdr.port = port;
        p.body.data.payload = w;
        store_entry(p, rs, 0, 1'b0);
    endtask

    task automatic cfg_entry(input logic [4:0] leaf, input logic [3:0] sel,
                             input logic [4:0] dl, input logic [3:0] dp);
        packet_t p;
        p = '0;
        p.hdr.valid = 1'b1;
        p.hdr.leaf = leaf;
        p.body.cfg.cfg_out = sel;
        p.body.cfg.dest_leaf = dl;
        p.body.cfg.dest_port = dp;
        store_entry(p, 1'b0, 0, 1'b0);
    endtask

    task automatic idle_entry(input int n, input logic rs, input logic mark);
        store_entry('0, rs, n - 1, mark);
    endtask

    // **************************************************
    // reference model
    // **************************************************
    function automatic packet_t make_result(input route_t r, input word_t w);
        packet_t p;
        p = '0;
        p.hdr.valid = 1'b1;
        p.hdr.leaf = r.dest_leaf;
        p.hdr.port = r.dest_port;
        p.body.data.payload = w;
        return p;
    endfunction

    task automatic model_apply(input packet_t p);
        int idx;
        if (p.hdr.valid) begin
            if (p.hdr.port == 4'd0) begin
                if (p.hdr.leaf == `LEAF_OWN_ID && p.body.cfg.cfg_out == 4'd1) begin
                    model_route_1 = {p.body.cfg.dest_leaf, p.body.cfg.dest_port};
                end else if (p.hdr.leaf == `LEAF_OWN_ID && p.body.cfg.cfg_out == 4'd2) begin
                    model_route_2 = {p.body.cfg.dest_leaf, p.body.cfg.dest_port};
                end
            end else if (p.hdr.port <= 4'd4) begin
                idx = int'(p.hdr.port) - 1;
                // a full queue loses the word
                if (mq[idx].size() < `LEAF_FIFO_DEPTH) begin
                    mq[idx].push_back(p.body.data.payload);
                end
            end
        end
        while (mq[0].size() > 0 && mq[1].size() > 0) begin
            exp_1.push_back(make_result(model_route_1, mq[0].pop_front() + mq[1].pop_front()));
        end
        while (mq[2].size() > 0 && mq[3].size() > 0) begin
            exp_2.push_back(make_result(model_route_2, mq[2].pop_front() ^ mq[3].pop_front()));
        end
    endtask

    // **************************************************
    // output monitor
    // **************************************************
    always @(posedge clk_400) begin
        if (arst_n) begin
            if (resend) begin
                check_packet("dout during resend", dout, '0);
            end
            if (dout.hdr.valid) begin
                if (dout.hdr.leaf == `TB_OUT1_LEAF && dout.hdr.port == `TB_OUT1_PORT
                    && exp_1.size() > 0) begin
                    out1_seen++;
                    check_word("output 1 payload", dout.body.data.payload,
                               exp_1[0].body.data.payload);
                    check_packet("output 1 packet", dout, exp_1.pop_front());
                end else if (dout.hdr.leaf == `TB_OUT2_LEAF && dout.hdr.port == `TB_OUT2_PORT
                             && exp_2.size() > 0) begin
                    check_word("output 2 payload", dout.body.data.payload,
                               exp_2[0].body.data.payload);
                    check_packet("output 2 packet", dout, exp_2.pop_front());
                end else begin
                    $display("unexpected packet on dout: %h", dout);
                    err_count++;
                end
            end else begin
                // an idle line carries no stray bits
                check_packet("dout idle", dout, '0);
            end
        end
    end

    initial begin
        wait (limit > 0);
        while (cycle <= limit) begin
            @(posedge clk_400);
            cycle++;
        end
        $display("timeout after %0d cycles, results still missing", cycle);
        $display("Checks failed");
        $finish;
    end

    // **************************************************
    // main sequence
    // **************************************************
    initial begin
        stim_t e;
        word_t a;
        word_t b;
        din = '0;
        resend = 1'b0;
        arst_n = 1'b0;
        err_count = 0;
        out1_seen = 0;
        mark_count = 0;
        cycle = 0;
        limit = 0;
        model_route_1 = '0;
        model_route_2 = '0;
        void'($urandom(32'ha033));

        idle_entry(6, 1'b0, 1'b0);
        cfg_entry(`LEAF_OWN_ID, 4'd1, `TB_OUT1_LEAF, `TB_OUT1_PORT);
        cfg_entry(`LEAF_OWN_ID, 4'd2, `TB_OUT2_LEAF, `TB_OUT2_PORT);
        // another leaf's configuration must be ignored
        cfg_entry(5'd7, 4'd1, 5'd20, 4'd7);
        idle_entry(3, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            data_entry(4'd1, $urandom, 1'b0);
            data_entry(4'd2, $urandom, 1'b0);
        end
        data_entry(4'd1, 32'hffff_fff0, 1'b0);
        data_entry(4'd2, 32'h0000_0020, 1'b0);
        idle_entry(10, 1'b0, 1'b0);
        // both outputs busy
        for (int i = 0; i < 4; i++) begin
            data_entry(4'd3, $urandom, 1'b0);
            data_entry(4'd1, $urandom, 1'b0);
            data_entry(4'd4, $urandom, 1'b0);
            data_entry(4'd2, $urandom, 1'b0);
        end
        idle_entry(12, 1'b0, 1'b0);
        // results are held while resend is high
        idle_entry(2, 1'b1, 1'b0);
        for (int i = 0; i < 3; i++) begin
            a = $urandom;
            b = $urandom;
            data_entry(4'd1, a, 1'b1);
            data_entry(4'd2, b, 1'b1);
            data_entry(4'd3, b, 1'b1);
            data_entry(4'd4, a, 1'b1);
        end
        idle_entry(10, 1'b1, 1'b0);
        idle_entry(25, 1'b0, 1'b0);
        // queue overflow on port 1 followed by partner words
        for (int i = 0; i < 10; i++) begin
            data_entry(4'd1, $urandom, 1'b0);
        end
        // count output 1 packets from here on
        idle_entry(4, 1'b0, 1'b1);
        for (int i = 0; i < 10; i++) begin
            data_entry(4'd2, $urandom, 1'b0);
            idle_entry(2, 1'b0, 1'b0);
        end

        repeat (3) @(posedge clk_400);
        @(negedge clk_400);
        arst_n = 1'b1;
        limit = (table_q.size() + 50) * 8;

        foreach (table_q[i]) begin
            e = table_q[i];
            @(negedge clk_400);
            din = e.pkt;
            resend = e.resend;
            if (e.mark) begin
                mark_count = out1_seen;
            end
            model_apply(e.pkt);
            repeat (e.idle) begin
                @(negedge clk_400);
                din = '0;
            end
        end
        @(negedge clk_400);
        din = '0;
        resend = 1'b0;

        while (exp_1.size() > 0 || exp_2.size() > 0) begin
            @(posedge clk_400);
        end
        repeat (10) @(posedge clk_400);
        check_word("output 1 packets after overflow", word_t'(out1_seen - mark_count),
                   word_t'(`LEAF_FIFO_DEPTH));

        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
hdl/leaf_pkg.sv
hdl/leaf_rx_demux.sv
hdl/leaf_port_fifo.sv
hdl/user_kernel.sv
hdl/leaf_tx_arbiter.sv
hdl/leaf_i4o2.sv
dv/leaf_i4o2_assert.sv
dv/leaf_i4o2_tb.sv

// File: hdl/leaf_i4o2.sv
module leaf_i4o2 (
    input  logic              clk_400,
    input  logic              arst_n,
    input  leaf_pkg::packet_t din,
    output leaf_pkg::packet_t dout,
    input  logic              resend
);
    import leaf_pkg::*;

    logic [3:0] wr;
    word_t      wr_word;
    route_t     route_1;
    route_t     route_2;

    logic [3:0] in_vld;
    logic [3:0] in_ack;
    word_t      in_word [4];

    word_t      out_word_1;
    word_t      out_word_2;
    logic       out_vld_1;
    logic       out_vld_2;
    logic       out_ack_1;
    logic       out_ack_2;

    // **************************************************
    // tree to user
    // **************************************************
    leaf_rx_demux rx_demux_inst (
        .clk_400 (clk_400),
        .arst_n  (arst_n),
        .din     (din),
        .wr      (wr),
        .wr_word (wr_word),
        .route_1 (route_1),
        .route_2 (route_2)
    );

    // one queue per user input with index 0 for port 1
    for (genvar i = 0; i < 4; i++) begin : g_port
        leaf_port_fifo port_fifo_inst (
            .clk_400 (clk_400),
            .arst_n  (arst_n),
            .wr      (wr[i]),
            .wr_word (wr_word),
            .ack     (in_ack[i]),
            .vld     (in_vld[i]),
            .word    (in_word[i])
        );
    end

    user_kernel user_kernel_inst (
        .clk_400    (clk_400),
        .arst_n     (arst_n),
        .in_word_1  (in_word[0]),
        .in_word_2  (in_word[1]),
        .in_word_3  (in_word[2]),
        .in_word_4  (in_word[3]),
        .in_vld_1   (in_vld[0]),
        .in_vld_2   (in_vld[1]),
        .in_vld_3   (in_vld[2]),
        .in_vld_4   (in_vld[3]),
        .in_ack_1   (in_ack[0]),
        .in_ack_2   (in_ack[1]),
        .in_ack_3   (in_ack[2]),
        .in_ack_4   (in_ack[3]),
        .out_word_1 (out_word_1),
        .out_word_2 (out_word_2),
        .out_vld_1  (out_vld_1),
        .out_vld_2  (out_vld_2),
        .out_ack_1  (out_ack_1),
        .out_ack_2  (out_ack_2)
    );

    // **************************************************
    // user to tree
    // **************************************************
    leaf_tx_arbiter tx_arbiter_inst (
        .clk_400    (clk_400),
        .arst_n     (arst_n),
        .resend     (resend),
        .out_word_1 (out_word_1),
        .out_word_2 (out_word_2),
        .out_vld_1  (out_vld_1),
        .out_vld_2  (out_vld_2),
        .out_ack_1  (out_ack_1),
        .out_ack_2  (out_ack_2),
        .route_1    (route_1),
        .route_2    (route_2),
        .dout       (dout)
    );

endmodule

// File: hdl/leaf_pkg.sv
`include "leaf_settings.svh"

package leaf_pkg;

    // **************************************************
    // packet header
    // **************************************************
    // valid is the per-cycle strobe on the tree side
    typedef struct packed {
        logic                             valid;
        logic [`LEAF_NUM_LEAF_BITS-1:0]   leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0]   port;
    } packet_hdr_t;

    // **************************************************
    // packet bodies
    // **************************************************
    // body of a data packet on port 1 to 4
    typedef struct packed {
        logic [`LEAF_NUM_ADDR_BITS-1:0]   addr;
        logic [`LEAF_PAYLOAD_BITS-1:0]    payload;
    } data_body_t;

    // body of a configuration packet on port 0
    typedef struct packed {
        logic [`LEAF_CFG_OUT_BITS-1:0]    cfg_out;
        logic [`LEAF_NUM_LEAF_BITS-1:0]   dest_leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0]   dest_port;
        logic [`LEAF_NUM_ADDR_BITS + `LEAF_PAYLOAD_BITS - `LEAF_CFG_OUT_BITS
               - `LEAF_NUM_LEAF_BITS - `LEAF_NUM_PORT_BITS - 1:0] reserved;
    } cfg_body_t;

    // the same 39 bits read by header port number
    typedef union packed {
        data_body_t data;
        cfg_body_t  cfg;
    } packet_body_u;

    typedef struct packed {
        packet_hdr_t  hdr;
        packet_body_u body;
    } packet_t;

    // **************************************************
    // user side
    // **************************************************
    typedef logic [`LEAF_PAYLOAD_BITS-1:0] word_t;

    // one routing table entry
    typedef struct packed {
        logic [`LEAF_NUM_LEAF_BITS-1:0]   dest_leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0]   dest_port;
    } route_t;

endpackage

// File: hdl/leaf_port_fifo.sv
`include "leaf_settings.svh"

module leaf_port_fifo (
    input  logic            clk_400,
    input  logic            arst_n,
    input  logic            wr,
    input  leaf_pkg::word_t wr_word,
    input  logic            ack,
    output logic            vld,
    output leaf_pkg::word_t word
);
    import leaf_pkg::*;

    localparam int PTR_BITS = $clog2(`LEAF_FIFO_DEPTH);

    word_t               mem [`LEAF_FIFO_DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [PTR_BITS:0]   count;
    logic                full;
    logic                push;
    logic                pop;

    // depth is a power of two, so the top count bit alone means full
    assign full = count[PTR_BITS];
    // writes while full are lost
    assign push = wr && !full;
    assign pop  = ack && vld;

    assign vld  = (count != '0);
    assign word = mem[head];

    always_ff @(posedge clk_400) begin
        if (push) begin
            mem[tail] <= wr_word;
        end
    end

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/leaf_rx_demux.sv
`include "leaf_settings.svh"

module leaf_rx_demux (
    input  logic              clk_400,
    input  logic              arst_n,
    input  leaf_pkg::packet_t din,
    output logic [3:0]        wr,
    output leaf_pkg::word_t   wr_word,
    output leaf_pkg::route_t  route_1,
    output leaf_pkg::route_t  route_2
);
    import leaf_pkg::*;

    packet_hdr_t  hdr_q;
    packet_body_u body_q;
    logic         is_cfg;
    logic         cfg_hit;
    route_t       cfg_route;

    // input register
    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            hdr_q <= '0;
        end else begin
            hdr_q <= din.hdr;
        end
    end

    always_ff @(posedge clk_400) begin
        if (din.hdr.valid) begin
            body_q <= din.body;
        end
    end

    // **************************************************
    // data packets to the port queues
    // **************************************************
    always_comb begin
        wr = '0;
        if (hdr_q.valid) begin
            case (hdr_q.port)
                4'd1:    wr = 4'b0001;
                4'd2:    wr = 4'b0010;
                4'd3:    wr = 4'b0100;
                4'd4:    wr = 4'b1000;
                default: wr = '0;
            endcase
        end
    end

    assign wr_word = body_q.data.payload;

    // **************************************************
    // configuration packets to the routing table
    // **************************************************
    assign is_cfg  = hdr_q.valid && (hdr_q.port == '0);
    // packets meant for another leaf leave the table alone
    assign cfg_hit = is_cfg && (hdr_q.leaf == `LEAF_OWN_ID);

    assign cfg_route.dest_leaf = body_q.cfg.dest_leaf;
    assign cfg_route.dest_port = body_q.cfg.dest_port;

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            route_1 <= '0;
            route_2 <= '0;
        end else if (cfg_hit) begin
            case (body_q.cfg.cfg_out)
                4'd1:    route_1 <= cfg_route;
                4'd2:    route_2 <= cfg_route;
                default: begin
                end
            endcase
        end
    end

endmodule

// File: hdl/leaf_tx_arbiter.sv
module leaf_tx_arbiter (
    input  logic              clk_400,
    input  logic              arst_n,
    input  logic              resend,
    input  leaf_pkg::word_t   out_word_1,
    input  leaf_pkg::word_t   out_word_2,
    input  logic              out_vld_1,
    input  logic              out_vld_2,
    output logic              out_ack_1,
    output logic              out_ack_2,
    input  leaf_pkg::route_t  route_1,
    input  leaf_pkg::route_t  route_2,
    output leaf_pkg::packet_t dout
);
    import leaf_pkg::*;

    logic    resend_q;
    logic    block;
    logic    hold;
    logic    grant_ok;
    // output 2 was the one served last
    logic    last_2;
    route_t  sel_route;
    word_t   sel_word;
    packet_t pkt;
    packet_t dout_q;

    // **************************************************
    // resend handling
    // **************************************************
    // the line stays quiet while resend is high and one cycle after it
    assign block    = resend | resend_q;
    // a packet caught by resend waits in the output register
    assign hold     = dout_q.hdr.valid & block;
    assign grant_ok = !resend && !hold;

    // **************************************************
    // round robin grant
    // **************************************************
    always_comb begin
        out_ack_1 = 1'b0;
        out_ack_2 = 1'b0;
        if (grant_ok) begin
            if (out_vld_1 && (!out_vld_2 || last_2)) begin
                out_ack_1 = 1'b1;
            end else if (out_vld_2) begin
                out_ack_2 = 1'b1;
            end
        end
    end

    assign sel_route = out_ack_2 ? route_2 : route_1;
    assign sel_word  = out_ack_2 ? out_word_2 : out_word_1;

    // packet build with the addr field left at zero
    always_comb begin
        pkt                   = '0;
        pkt.hdr.valid         = 1'b1;
        pkt.hdr.leaf          = sel_route.dest_leaf;
        pkt.hdr.port          = sel_route.dest_port;
        pkt.body.data.addr    = '0;
        pkt.body.data.payload = sel_word;
    end

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            resend_q <= 1'b0;
            last_2   <= 1'b1;
            dout_q   <= '0;
        end else begin
            resend_q <= resend;
            if (out_ack_1 || out_ack_2) begin
                dout_q <= pkt;
                last_2 <= out_ack_2;
            end else if (!block) begin
                // current word went out this cycle
                dout_q <= '0;
            end
        end
    end

    assign dout = block ? '0 : dout_q;

endmodule

// File: hdl/user_kernel.sv
module user_kernel (
    input  logic            clk_400,
    input  logic            arst_n,
    input  leaf_pkg::word_t in_word_1,
    input  leaf_pkg::word_t in_word_2,
    input  leaf_pkg::word_t in_word_3,
    input  leaf_pkg::word_t in_word_4,
    input  logic            in_vld_1,
    input  logic            in_vld_2,
    input  logic            in_vld_3,
    input  logic            in_vld_4,
    output logic            in_ack_1,
    output logic            in_ack_2,
    output logic            in_ack_3,
    output logic            in_ack_4,
    output leaf_pkg::word_t out_word_1,
    output leaf_pkg::word_t out_word_2,
    output logic            out_vld_1,
    output logic            out_vld_2,
    input  logic            out_ack_1,
    input  logic            out_ack_2
);
    import leaf_pkg::*;

    // bit 0 is the sum unit, bit 1 the xor unit
    logic [1:0] take;
    logic [1:0] res_vld;
    word_t      sum_q;
    word_t      xor_q;

    // a pair is taken when both words wait and the result slot is free
    assign take[0] = in_vld_1 & in_vld_2 & ~res_vld[0];
    assign take[1] = in_vld_3 & in_vld_4 & ~res_vld[1];

    assign in_ack_1 = take[0];
    assign in_ack_2 = take[0];
    assign in_ack_3 = take[1];
    assign in_ack_4 = take[1];

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            res_vld <= '0;
        end else begin
            res_vld[0] <= take[0] | (res_vld[0] & ~out_ack_1);
            res_vld[1] <= take[1] | (res_vld[1] & ~out_ack_2);
        end
    end

    // sum wraps at 32 bits
    always_ff @(posedge clk_400) begin
        if (take[0]) begin
            sum_q <= in_word_1 + in_word_2;
        end
        if (take[1]) begin
            xor_q <= in_word_3 ^ in_word_4;
        end
    end

    assign out_vld_1  = res_vld[0];
    assign out_vld_2  = res_vld[1];
    assign out_word_1 = sum_q;
    assign out_word_2 = xor_q;

endmodule

// File: include/leaf_settings.svh
`ifndef LEAF_SETTINGS_SVH
`define LEAF_SETTINGS_SVH

// **************************************************
// packet field widths
// **************************************************
`define LEAF_NUM_LEAF_BITS 5
`define LEAF_NUM_PORT_BITS 4
`define LEAF_NUM_ADDR_BITS 7
`define LEAF_PAYLOAD_BITS  32
`define LEAF_CFG_OUT_BITS  4

// **************************************************
// this leaf
// **************************************************
// words per user input queue
// must be a power of two
`define LEAF_FIFO_DEPTH 8
// leaf number that configuration packets must carry
`define LEAF_OWN_ID 5'd3

`endif

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module leaf_i4o2_tb -o leaf_sim

out=$(./obj_dir/leaf_sim)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
else
    exit 1
fi
